// File: common/axi_check_pkg.sv
/*
 * Shared constants and enumerations for the AXI4 protocol checker.
 * Modules refer to these by scoped name, never through an import.
 */

`default_nettype none

package axi_check_pkg;

	// Bus field widths for the 64-bit link being observed
	localparam int addr_width  = 32;
	localparam int data_width  = 64;
	localparam int strb_width  = 8;
	localparam int len_width   = 8;
	localparam int size_width  = 3;
	localparam int burst_width = 2;
	localparam int resp_width  = 2;

	// Outstanding bursts tracked per direction before overflow is flagged
	localparam int track_depth = 4;

	// Width of the saturating violation counter
	localparam int count_width = 16;

	// Violation codes in priority order
	// The lowest non-zero value wins when several checks fire together
	typedef enum logic [3:0] {
		chk_none,
		chk_aw_hold,
		chk_w_hold,
		chk_b_hold,
		chk_ar_hold,
		chk_r_hold,
		chk_b_early,
		chk_w_no_addr,
		chk_wlast,
		chk_rlast,
		chk_track_overflow
	} check_code_e;

	// Beat counting state of a burst tracker
	// Idle means the next beat is the first beat of the head burst
	typedef enum logic [0:0] {
		beat_idle,
		beat_busy
	} burst_state_e;

endpackage

`default_nettype wire

// File: read/read_burst_tracker.sv
/*
 * Read side burst tracking for the AXI4 checker.
 * Checks rlast on every read beat against the length buffered at the
 * address handshake. A read beat with no buffered length also fails.
 */

`timescale 1ns/1ps
`default_nettype none

module read_burst_tracker (
	input  logic                               aclk,
	input  logic                               reset,
	input  logic                               arvalid,
	input  logic                               arready,
	input  logic [axi_check_pkg::len_width-1:0] arlen,
	input  logic                               rvalid,
	input  logic                               rready,
	input  logic                               rlast,
	output logic                               rlast_error,
	output logic                               overflow_error
);

	logic ar_hs;
	logic r_hs;

	logic [axi_check_pkg::len_width-1:0] head_len;
	logic                               empty;
	logic                               end_beat;
	logic                               burst_done;

	axi_check_pkg::burst_state_e         state;
	logic [axi_check_pkg::len_width-1:0] beat_cnt;

	assign ar_hs = arvalid & arready;
	assign r_hs  = rvalid & rready;

	len_fifo #(
		.depth (axi_check_pkg::track_depth)
	) u_len_fifo (
		.aclk     (aclk),
		.reset    (reset),
		.push     (ar_hs),
		.pop      (burst_done),
		.push_len (arlen),
		.head_len (head_len),
		.empty    (empty),
		.overflow (overflow_error)
	);

	// In idle the next beat is the first one of the head burst
	assign end_beat = (state == axi_check_pkg::beat_idle) ? (head_len == '0)
		: (beat_cnt == head_len);

	// An early rlast closes the burst so later bursts stay aligned
	assign burst_done = r_hs & ~empty & (rlast | end_beat);

	// Read data with no outstanding address is reported as a last-beat error too
	assign rlast_error = r_hs & (empty | (rlast != end_beat));

	always_ff @(posedge aclk) begin
		if (reset) begin
			state    <= axi_check_pkg::beat_idle;
			beat_cnt <= '0;
		end else if (burst_done) begin
			state    <= axi_check_pkg::beat_idle;
			beat_cnt <= '0;
		end else if (r_hs && !empty) begin
			state    <= axi_check_pkg::beat_busy;
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the AXI4 checker testbench with Verilator, runs it and checks the log.
rm -rf obj_dir sim.log
verilator --binary --timing -f verilog.f --top-module tb_axi4_protocol_checker \
	-o tb_sim && ./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log 2>/dev/null
grep -q "tests failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "all tests passed" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation PASSED"
exit 0

// File: src/axi4_protocol_checker.sv
/*
 * Passive AXI4 protocol checker for a 64-bit link.
 * Every bus signal is an input; rule breaks come out as coded pulses
 * one cycle after the offending edge.
 */

`timescale 1ns/1ps
`default_nettype none

module axi4_protocol_checker (
	input  logic                                   aclk,
	input  logic                                   reset,
	input  logic [axi_check_pkg::addr_width-1:0]   awaddr,
	input  logic [axi_check_pkg::len_width-1:0]    awlen,
	input  logic [axi_check_pkg::size_width-1:0]   awsize,
	input  logic [axi_check_pkg::burst_width-1:0]  awburst,
	input  logic                                   awvalid,
	input  logic                                   awready,
	input  logic [axi_check_pkg::data_width-1:0]   wdata,
	input  logic [axi_check_pkg::strb_width-1:0]   wstrb,
	input  logic                                   wlast,
	input  logic                                   wvalid,
	input  logic                                   wready,
	input  logic [axi_check_pkg::resp_width-1:0]   bresp,
	input  logic                                   bvalid,
	input  logic                                   bready,
	input  logic [axi_check_pkg::addr_width-1:0]   araddr,
	input  logic [axi_check_pkg::len_width-1:0]    arlen,
	input  logic [axi_check_pkg::size_width-1:0]   arsize,
	input  logic [axi_check_pkg::burst_width-1:0]  arburst,
	input  logic                                   arvalid,
	input  logic                                   arready,
	input  logic [axi_check_pkg::data_width-1:0]   rdata,
	input  logic [axi_check_pkg::resp_width-1:0]   rresp,
	input  logic                                   rlast,
	input  logic                                   rvalid,
	input  logic                                   rready,
	output logic                                   violation,
	output axi_check_pkg::check_code_e             violation_code,
	output axi_check_pkg::check_code_e             first_code,
	output logic [axi_check_pkg::count_width-1:0]  error_count
);

	logic aw_hold, w_hold, b_hold, ar_hold, r_hold;
	logic wlast_err, w_no_addr, b_early, w_overflow;
	logic rlast_err, r_overflow;

	// Address channel payload is address, length, size and burst type
	hold_checker #(
		.width (axi_check_pkg::addr_width + axi_check_pkg::len_width
			+ axi_check_pkg::size_width + axi_check_pkg::burst_width)
	) u_aw_hold (
		.aclk (aclk), .reset (reset), .valid (awvalid), .ready (awready),
		.payload ({awaddr, awlen, awsize, awburst}), .hold_error (aw_hold)
	);

	hold_checker #(
		.width (axi_check_pkg::data_width + axi_check_pkg::strb_width + 1)
	) u_w_hold (
		.aclk (aclk), .reset (reset), .valid (wvalid), .ready (wready),
		.payload ({wdata, wstrb, wlast}), .hold_error (w_hold)
	);

	hold_checker #(
		.width (axi_check_pkg::resp_width)
	) u_b_hold (
		.aclk (aclk), .reset (reset), .valid (bvalid), .ready (bready),
		.payload (bresp), .hold_error (b_hold)
	);

	hold_checker #(
		.width (axi_check_pkg::addr_width + axi_check_pkg::len_width
			+ axi_check_pkg::size_width + axi_check_pkg::burst_width)
	) u_ar_hold (
		.aclk (aclk), .reset (reset), .valid (arvalid), .ready (arready),
		.payload ({araddr, arlen, arsize, arburst}), .hold_error (ar_hold)
	);

	hold_checker #(
		.width (axi_check_pkg::data_width + axi_check_pkg::resp_width + 1)
	) u_r_hold (
		.aclk (aclk), .reset (reset), .valid (rvalid), .ready (rready),
		.payload ({rdata, rresp, rlast}), .hold_error (r_hold)
	);

	write_burst_tracker u_write_burst_tracker (
		.aclk (aclk), .reset (reset),
		.awvalid (awvalid), .awready (awready), .awlen (awlen),
		.wvalid (wvalid), .wready (wready), .wlast (wlast),
		.bvalid (bvalid), .bready (bready),
		.wlast_error (wlast_err), .no_addr_error (w_no_addr),
		.b_early_error (b_early), .overflow_error (w_overflow)
	);

	read_burst_tracker u_read_burst_tracker (
		.aclk (aclk), .reset (reset),
		.arvalid (arvalid), .arready (arready), .arlen (arlen),
		.rvalid (rvalid), .rready (rready), .rlast (rlast),
		.rlast_error (rlast_err), .overflow_error (r_overflow)
	);

	// Either direction running out of tracking slots shares one code
	violation_logger u_violation_logger (
		.aclk (aclk), .reset (reset),
		.aw_hold (aw_hold), .w_hold (w_hold), .b_hold (b_hold),
		.ar_hold (ar_hold), .r_hold (r_hold),
		.b_early (b_early), .w_no_addr (w_no_addr),
		.wlast_err (wlast_err), .rlast_err (rlast_err),
		.track_overflow (w_overflow | r_overflow),
		.violation (violation), .violation_code (violation_code),
		.first_code (first_code), .error_count (error_count)
	);

endmodule

`default_nettype wire

// File: src/hold_checker.sv
/*
 * Payload hold check for one AXI4 channel.
 * Flags a stalled transfer whose valid drops or whose payload changes.
 */

`timescale 1ns/1ps
`default_nettype none

module hold_checker #(
	parameter int width = axi_check_pkg::data_width
) (
	input  logic             aclk,
	input  logic             reset,
	input  logic             valid,
	input  logic             ready,
	input  logic [width-1:0] payload,
	output logic             hold_error
);

	// Copy of the payload seen at the previous edge
	logic [width-1:0] payload_q;

	// Set when the previous edge saw valid high with ready low
	logic stalled_q;

	always_ff @(posedge aclk) begin
		if (reset) begin
			stalled_q <= 1'b0;
		end else begin
			stalled_q <= valid & ~ready;
		end
	end

	// The copy is compared with the live payload while stalled_q is set
	always_ff @(posedge aclk) begin
		payload_q <= payload;
	end

	// A stalled transfer must keep valid high and the payload untouched
	// until the handshake completes
	always_comb begin
		hold_error = 1'b0;
		if (stalled_q) begin
			if (!valid || payload != payload_q) begin
				hold_error = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/len_fifo.sv
/*
 * Circular buffer of outstanding burst lengths for a burst tracker.
 * Push on an address handshake, pop when the head burst ends.
 * A push into a full buffer is dropped and pulses overflow.
 */

`timescale 1ns/1ps
`default_nettype none

module len_fifo #(
	parameter int depth = axi_check_pkg::track_depth
) (
	input  logic                               aclk,
	input  logic                               reset,
	input  logic                               push,
	input  logic                               pop,
	input  logic [axi_check_pkg::len_width-1:0] push_len,
	output logic [axi_check_pkg::len_width-1:0] head_len,
	output logic                               empty,
	output logic                               overflow
);

	// Length storage read at the head pointer
	logic [axi_check_pkg::len_width-1:0] mem [depth];

	logic [$clog2(depth)-1:0]   rd_ptr;
	logic [$clog2(depth)-1:0]   wr_ptr;
	logic [$clog2(depth+1)-1:0] count;

	logic full;
	logic do_push;
	logic do_pop;

	assign empty = (count == '0);
	assign full  = (count == ($clog2(depth+1))'(depth));

	// A pop in the same cycle frees the slot, so a push into a full buffer is kept
	assign do_pop   = pop & ~empty;
	assign do_push  = push & (~full | do_pop);
	assign overflow = push & full & ~do_pop;

	assign head_len = mem[rd_ptr];

	always_ff @(posedge aclk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_len;
		end
	end

	// Pointers wrap explicitly so the depth need not be a power of two
	always_ff @(posedge aclk) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				if (wr_ptr == ($clog2(depth))'(depth - 1)) begin
					wr_ptr <= '0;
				end else begin
					wr_ptr <= wr_ptr + 1'b1;
				end
			end
			if (do_pop) begin
				if (rd_ptr == ($clog2(depth))'(depth - 1)) begin
					rd_ptr <= '0;
				end else begin
					rd_ptr <= rd_ptr + 1'b1;
				end
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/violation_logger.sv
/*
 * Collects the violation flags of all checks one cycle after they fire.
 * Reports the highest-priority code, keeps the first code since reset
 * and counts faulty cycles up to saturation.
 */

`timescale 1ns/1ps
`default_nettype none

module violation_logger (
	input  logic                                 aclk,
	input  logic                                 reset,
	input  logic                                 aw_hold,
	input  logic                                 w_hold,
	input  logic                                 b_hold,
	input  logic                                 ar_hold,
	input  logic                                 r_hold,
	input  logic                                 b_early,
	input  logic                                 w_no_addr,
	input  logic                                 wlast_err,
	input  logic                                 rlast_err,
	input  logic                                 track_overflow,
	output logic                                 violation,
	output axi_check_pkg::check_code_e           violation_code,
	output axi_check_pkg::check_code_e           first_code,
	output logic [axi_check_pkg::count_width-1:0] error_count
);

	axi_check_pkg::check_code_e code_next;

	// The priority encoder lets the lowest code value win
	always_comb begin
		if (aw_hold) begin
			code_next = axi_check_pkg::chk_aw_hold;
		end else if (w_hold) begin
			code_next = axi_check_pkg::chk_w_hold;
		end else if (b_hold) begin
			code_next = axi_check_pkg::chk_b_hold;
		end else if (ar_hold) begin
			code_next = axi_check_pkg::chk_ar_hold;
		end else if (r_hold) begin
			code_next = axi_check_pkg::chk_r_hold;
		end else if (b_early) begin
			code_next = axi_check_pkg::chk_b_early;
		end else if (w_no_addr) begin
			code_next = axi_check_pkg::chk_w_no_addr;
		end else if (wlast_err) begin
			code_next = axi_check_pkg::chk_wlast;
		end else if (rlast_err) begin
			code_next = axi_check_pkg::chk_rlast;
		end else if (track_overflow) begin
			code_next = axi_check_pkg::chk_track_overflow;
		end else begin
			code_next = axi_check_pkg::chk_none;
		end
	end

	// All outputs change together on the edge after the offending inputs
	always_ff @(posedge aclk) begin
		if (reset) begin
			violation      <= 1'b0;
			violation_code <= axi_check_pkg::chk_none;
			first_code     <= axi_check_pkg::chk_none;
			error_count    <= '0;
		end else begin
			violation      <= (code_next != axi_check_pkg::chk_none);
			violation_code <= code_next;
			// First code is sticky until the next reset
			if (first_code == axi_check_pkg::chk_none) begin
				first_code <= code_next;
			end
			if (code_next != axi_check_pkg::chk_none && error_count != '1) begin
				error_count <= error_count + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: verif/tb_axi4_protocol_checker.sv
/*
 * Testbench for the passive AXI4 protocol checker.
 * Drives clean and faulty bus traffic and checks the violation outputs every cycle
 * against a model built from the injected fault of each cycle.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_axi4_protocol_checker;

	// Sized for a clean scenario with four bursts of eight beats on each side
	localparam int num_scenarios   = 15;
	localparam int scenario_cycles = 300;

	// Fault placed on the bus in a given cycle
	typedef enum {
		no_fault, aw_break, w_break, b_break, ar_break, r_break, b_before_w,
		w_without_aw, wrong_wlast, wrong_rlast, too_many_aw, w_break_wlast
	} fault_e;

	logic aclk;
	logic reset;
	logic [31:0] awaddr, araddr;
	logic [7:0] awlen, arlen;
	logic [2:0] awsize, arsize;
	logic [1:0] awburst, arburst, bresp, rresp;
	logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rlast, rvalid, rready;
	logic [63:0] wdata, rdata;
	logic [7:0] wstrb;
	logic violation;
	axi_check_pkg::check_code_e violation_code, first_code;
	logic [axi_check_pkg::count_width-1:0] error_count;

	fault_e fault_kind;

	axi4_protocol_checker u_axi4_protocol_checker (
		.aclk (aclk), .reset (reset),
		.awaddr (awaddr), .awlen (awlen), .awsize (awsize), .awburst (awburst),
		.awvalid (awvalid), .awready (awready),
		.wdata (wdata), .wstrb (wstrb), .wlast (wlast), .wvalid (wvalid), .wready (wready),
		.bresp (bresp), .bvalid (bvalid), .bready (bready),
		.araddr (araddr), .arlen (arlen), .arsize (arsize), .arburst (arburst),
		.arvalid (arvalid), .arready (arready),
		.rdata (rdata), .rresp (rresp), .rlast (rlast), .rvalid (rvalid), .rready (rready),
		.violation (violation), .violation_code (violation_code),
		.first_code (first_code), .error_count (error_count)
	);

	initial begin
		aclk = 1'b0;
		forever #50 aclk = ~aclk;
	end

	// Expected code for each fault kind following the priority order of the codes
	function automatic axi_check_pkg::check_code_e expected_code(input fault_e f);
		case (f)
			aw_break:     return axi_check_pkg::chk_aw_hold;
			w_break:      return axi_check_pkg::chk_w_hold;
			b_break:      return axi_check_pkg::chk_b_hold;
			ar_break:     return axi_check_pkg::chk_ar_hold;
			r_break:      return axi_check_pkg::chk_r_hold;
			b_before_w:   return axi_check_pkg::chk_b_early;
			w_without_aw: return axi_check_pkg::chk_w_no_addr;
			wrong_wlast:  return axi_check_pkg::chk_wlast;
			wrong_rlast:  return axi_check_pkg::chk_rlast;
			too_many_aw:  return axi_check_pkg::chk_track_overflow;
			// The W hold break outranks the wrong wlast in the same cycle
			w_break_wlast: return axi_check_pkg::chk_w_hold;
			default:      return axi_check_pkg::chk_none;
		endcase
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
			$display("tests failed");
			$fatal(1, "Output mismatch");
		end
	endtask

	task automatic idle_bus();
		{awaddr, awlen, awsize, awburst, awvalid, awready} = '0;
		{wdata, wstrb, wlast, wvalid, wready} = '0;
		{bresp, bvalid, bready} = '0;
		{araddr, arlen, arsize, arburst, arvalid, arready} = '0;
		{rdata, rresp, rlast, rvalid, rready} = '0;
		fault_kind = no_fault;
	endtask

	task automatic apply_reset();
		idle_bus();
		reset = 1'b1;
		repeat (8) @(negedge aclk);
		reset = 1'b0;
	endtask

	// A hold break stalls one cycle, then changes the payload on the handshake
	task automatic write_address(input int len, input fault_e f);
		int stall;
		stall = (f == aw_break) ? 1 : $urandom % 3;
		awaddr = $urandom;
		awlen = 8'(len);
		awsize = 3'd3;
		awburst = 2'd1;
		awvalid = 1'b1;
		awready = 1'b0;
		repeat (stall) @(negedge aclk);
		if (f == aw_break) begin
			awaddr = ~awaddr;
		end
		awready = 1'b1;
		fault_kind = f;
		@(negedge aclk);
		awvalid = 1'b0;
		awready = 1'b0;
		fault_kind = no_fault;
	endtask

	task automatic read_address(input int len, input fault_e f);
		int stall;
		stall = (f == ar_break) ? 1 : $urandom % 3;
		araddr = $urandom;
		arlen = 8'(len);
		arsize = 3'd3;
		arburst = 2'd1;
		arvalid = 1'b1;
		arready = 1'b0;
		repeat (stall) @(negedge aclk);
		if (f == ar_break) begin
			araddr = ~araddr;
		end
		arready = 1'b1;
		fault_kind = f;
		@(negedge aclk);
		arvalid = 1'b0;
		arready = 1'b0;
		fault_kind = no_fault;
	endtask

	// Last is set on beat last_beat; the burst stops at that beat or at beat len
	task automatic write_beats(input int len, input int last_beat, input fault_e f);
		int stall;
		int final_beat;
		int i;
		final_beat = (last_beat < len) ? last_beat : len;
		for (i = 0; i <= final_beat; i++) begin
			stall = (i == final_beat && f inside {w_break, w_break_wlast}) ? 1 : $urandom % 3;
			wdata = {$urandom, $urandom};
			wstrb = '1;
			wlast = (i == last_beat);
			wvalid = 1'b1;
			wready = 1'b0;
			repeat (stall) @(negedge aclk);
			if (i == final_beat) begin
				if (f inside {w_break, w_break_wlast}) begin
					wdata = ~wdata;
				end
				fault_kind = f;
			end
			wready = 1'b1;
			@(negedge aclk);
			fault_kind = no_fault;
		end
		wvalid = 1'b0;
		wready = 1'b0;
	endtask

	task automatic read_beats(input int len, input int last_beat, input fault_e f);
		int stall;
		int final_beat;
		int i;
		final_beat = (last_beat < len) ? last_beat : len;
		for (i = 0; i <= final_beat; i++) begin
			stall = (i == final_beat && f == r_break) ? 1 : $urandom % 3;
			rdata = {$urandom, $urandom};
			rresp = 2'b00;
			rlast = (i == last_beat);
			rvalid = 1'b1;
			rready = 1'b0;
			repeat (stall) @(negedge aclk);
			if (i == final_beat) begin
				if (f == r_break) begin
					rdata = ~rdata;
				end
				fault_kind = f;
			end
			rready = 1'b1;
			@(negedge aclk);
			fault_kind = no_fault;
		end
		rvalid = 1'b0;
		rready = 1'b0;
	endtask

	task automatic write_response(input fault_e f);
		int stall;
		stall = (f == b_break) ? 1 : $urandom % 3;
		bresp = 2'b00;
		bvalid = 1'b1;
		bready = 1'b0;
		repeat (stall) @(negedge aclk);
		if (f == b_break) begin
			bresp = 2'b10;
		end
		bready = 1'b1;
		fault_kind = f;
		@(negedge aclk);
		bvalid = 1'b0;
		bready = 1'b0;
		fault_kind = no_fault;
	endtask

	// Up to track_depth bursts per direction in flight with responses after all data
	task automatic clean_traffic();
		int lens [axi_check_pkg::track_depth];
		int n;
		int i;
		n = 1 + $urandom % axi_check_pkg::track_depth;
		for (i = 0; i < n; i++) begin
			lens[i] = $urandom % 8;
			write_address(lens[i], no_fault);
		end
		for (i = 0; i < n; i++) write_beats(lens[i], lens[i], no_fault);
		for (i = 0; i < n; i++) write_response(no_fault);
		for (i = 0; i < n; i++) begin
			lens[i] = $urandom % 8;
			read_address(lens[i], no_fault);
		end
		for (i = 0; i < n; i++) read_beats(lens[i], lens[i], no_fault);
	endtask

	// The logger model expects inputs sampled at a rising edge to show up after it
	initial begin
		fault_e seen_kind;
		logic seen_reset;
		axi_check_pkg::check_code_e exp_code;
		axi_check_pkg::check_code_e exp_first;
		logic [axi_check_pkg::count_width-1:0] exp_count;
		exp_first = axi_check_pkg::chk_none;
		exp_count = '0;
		forever begin
			@(posedge aclk);
			seen_kind = fault_kind;
			seen_reset = reset;
			@(negedge aclk);
			if (seen_reset) begin
				exp_code = axi_check_pkg::chk_none;
				exp_first = axi_check_pkg::chk_none;
				exp_count = '0;
			end else begin
				exp_code = expected_code(seen_kind);
				if (exp_first == axi_check_pkg::chk_none) exp_first = exp_code;
				if (exp_code != axi_check_pkg::chk_none && exp_count != '1) begin
					exp_count = exp_count + 1'b1;
				end
			end
			check_value("violation", 32'(violation), 32'(exp_code != axi_check_pkg::chk_none));
			check_value("violation_code", 32'(violation_code), 32'(exp_code));
			check_value("first_code", 32'(first_code), 32'(exp_first));
			check_value("error_count", 32'(error_count), 32'(exp_count));
		end
	end

	initial begin
		repeat (num_scenarios * scenario_cycles + 50) @(posedge aclk);
		$display("Timeout: the scenarios did not finish in the expected number of cycles");
		$display("tests failed");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		void'($urandom(32'hce26ddba));
		reset = 1'b1;
		idle_bus();
		repeat (3) begin
			apply_reset();
			clean_traffic();
		end
		// One hold break per channel
		apply_reset();
		write_address(0, aw_break);
		apply_reset();
		write_address(0, no_fault);
		write_beats(0, 0, w_break);
		apply_reset();
		write_address(0, no_fault);
		write_beats(0, 0, no_fault);
		write_response(b_break);
		apply_reset();
		read_address(0, ar_break);
		apply_reset();
		read_address(1, no_fault);
		read_beats(1, 1, r_break);
		// Early and late wlast, early rlast
		apply_reset();
		write_address(3, no_fault);
		write_beats(3, 1, wrong_wlast);
		apply_reset();
		write_address(1, no_fault);
		write_beats(1, 2, wrong_wlast);
		apply_reset();
		read_address(3, no_fault);
		read_beats(3, 0, wrong_rlast);
		// Response before any data, then data before any address
		apply_reset();
		write_address(1, no_fault);
		write_response(b_before_w);
		apply_reset();
		write_beats(0, 0, w_without_aw);
		// Two checks in one cycle, then more faults behind the first one
		apply_reset();
		write_address(2, no_fault);
		write_beats(2, 1, w_break_wlast);
		write_beats(0, 0, w_without_aw);
		read_beats(0, 0, wrong_rlast);
		// One address more than the tracker holds
		apply_reset();
		repeat (axi_check_pkg::track_depth) write_address(0, no_fault);
		write_address(0, too_many_aw);
		repeat (3) @(negedge aclk);
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
common/axi_check_pkg.sv
src/hold_checker.sv
src/len_fifo.sv
write/write_burst_tracker.sv
read/read_burst_tracker.sv
src/violation_logger.sv
src/axi4_protocol_checker.sv
verif/tb_axi4_protocol_checker.sv

// File: write/write_burst_tracker.sv
/*
 * Write side burst tracking for the AXI4 checker.
 * Checks wlast against the buffered burst length, write data without an
 * address, and write responses that arrive before their burst is done.
 */

`timescale 1ns/1ps
`default_nettype none

module write_burst_tracker (
	input  logic                               aclk,
	input  logic                               reset,
	input  logic                               awvalid,
	input  logic                               awready,
	input  logic [axi_check_pkg::len_width-1:0] awlen,
	input  logic                               wvalid,
	input  logic                               wready,
	input  logic                               wlast,
	input  logic                               bvalid,
	input  logic                               bready,
	output logic                               wlast_error,
	output logic                               no_addr_error,
	output logic                               b_early_error,
	output logic                               overflow_error
);

	logic aw_hs;
	logic w_hs;
	logic b_hs;

	logic [axi_check_pkg::len_width-1:0] head_len;
	logic                               empty;
	logic                               end_beat;
	logic                               burst_done;

	// Completed beats of the head burst while busy
	axi_check_pkg::burst_state_e         state;
	logic [axi_check_pkg::len_width-1:0] beat_cnt;

	// Address handshakes and finished bursts still waiting for a response
	logic [axi_check_pkg::len_width-1:0] aw_pending;
	logic [axi_check_pkg::len_width-1:0] burst_pending;
	logic                               b_ok;

	assign aw_hs = awvalid & awready;
	assign w_hs  = wvalid & wready;
	assign b_hs  = bvalid & bready;

	len_fifo #(
		.depth (axi_check_pkg::track_depth)
	) u_len_fifo (
		.aclk     (aclk),
		.reset    (reset),
		.push     (aw_hs),
		.pop      (burst_done),
		.push_len (awlen),
		.head_len (head_len),
		.empty    (empty),
		.overflow (overflow_error)
	);

	// The current beat is number beat_cnt plus one and the last is head_len plus one
	assign end_beat = (state == axi_check_pkg::beat_idle) ? (head_len == '0)
		: (beat_cnt == head_len);

	// A burst ends on its expected last beat or on an early wlast
	assign burst_done    = w_hs & ~empty & (wlast | end_beat);
	assign wlast_error   = w_hs & ~empty & (wlast != end_beat);
	assign no_addr_error = w_hs & empty;

	assign b_ok          = (aw_pending != '0) && (burst_pending != '0);
	assign b_early_error = b_hs & ~b_ok;

	always_ff @(posedge aclk) begin
		if (reset) begin
			state    <= axi_check_pkg::beat_idle;
			beat_cnt <= '0;
		end else if (burst_done) begin
			state    <= axi_check_pkg::beat_idle;
			beat_cnt <= '0;
		end else if (w_hs && !empty) begin
			state    <= axi_check_pkg::beat_busy;
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	// Only a response that passes the check retires an entry from both counts
	always_ff @(posedge aclk) begin
		if (reset) begin
			aw_pending    <= '0;
			burst_pending <= '0;
		end else begin
			if (aw_hs && !(b_hs && b_ok) && aw_pending != '1) begin
				aw_pending <= aw_pending + 1'b1;
			end else if (!aw_hs && b_hs && b_ok) begin
				aw_pending <= aw_pending - 1'b1;
			end
			if (burst_done && !(b_hs && b_ok) && burst_pending != '1) begin
				burst_pending <= burst_pending + 1'b1;
			end else if (!burst_done && b_hs && b_ok) begin
				burst_pending <= burst_pending - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire
